// File: rtl/memPkg.sv
package memPkg;

    localparam int dataBits = 32;
    localparam int lineBits = 64;
    localparam int wordAddrBits = 30;

    // data sram size in words, instruction sram size in lines.
    localparam int dcacheDepth = 1024;
    localparam int icacheDepth = 512;

    localparam int sramAddrBits = $clog2(dcacheDepth);
    localparam int lineAddrBits = $clog2(icacheDepth);

    typedef logic [dataBits-1:0] dataWord;
    typedef logic [lineBits-1:0] lineWord;
    typedef logic [dataBits/8-1:0] byteMask;
    typedef logic [lineBits/8-1:0] lineMask;

    // core side word address, wider than either sram.
    typedef logic [wordAddrBits-1:0] wordAddr;

    typedef logic [sramAddrBits-1:0] sramAddr;

    // instruction line index.
    typedef logic [lineAddrBits-1:0] lineAddr;

endpackage

// File: rtl/xferPkg.sv
package xferPkg;

    localparam int burstLen = 16;
    localparam int extAddrBits = 30;
    localparam int progressBits = 10;

    // set in the command word for an external write.
    localparam int cmdWriteBit = 31;

    // beat counter covers the whole busy window.
    localparam int beatBits = $clog2(burstLen + 4);

    typedef logic [extAddrBits-1:0] extAddr;
    typedef logic [0:0] cacheSel;
    typedef logic [progressBits-1:0] progressCount;

    localparam cacheSel selDcache = 1'b0;
    localparam cacheSel selIcache = 1'b1;

    typedef enum logic [1:0] {
        idle,
        command,
        stream,
        drain
    } ctrlState;

    function automatic logic [cmdWriteBit:0] cmdWord(input logic write, input extAddr addr);
        logic [cmdWriteBit:0] word;
        word = '0;
        word[extAddrBits-1:0] = addr;
        word[cmdWriteBit] = write;
        return word;
    endfunction

endpackage

// File: rtl/sramDualPort.sv
module sramDualPort #(
    parameter int dataWidth = 32,
    parameter int depth = 1024
) (
    input  logic                     clk,

    // port 0, masked write or read.
    input  logic                     ceN,
    input  logic                     weN,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic [dataWidth-1:0]     wrData,
    input  logic [dataWidth/8-1:0]   wrMask,
    output logic [dataWidth-1:0]     rdData,

    // port 1, read only.
    input  logic                     ceN1,
    input  logic [$clog2(depth)-1:0] addr1,
    output logic [dataWidth-1:0]     rdData1
);

    logic [dataWidth-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (!ceN) begin
            if (!weN) begin
                for (int i = 0; i < dataWidth / 8; i++) begin
                    if (wrMask[i]) begin
                        mem[addr][i*8 +: 8] <= wrData[i*8 +: 8];
                    end
                end
            end else begin
                rdData <= mem[addr];
            end
        end
    end

    // output holds while the port is disabled.
    always_ff @(posedge clk) begin
        if (!ceN1) begin
            rdData1 <= mem[addr1];
        end
    end

endmodule

// File: rtl/memController.sv
module memController
    import memPkg::*, xferPkg::*;
(
    input  logic         clk,
    input  logic         rstN,

    // transfer command, one cycle strobe.
    input  logic         mcCe,
    input  logic         mcWe,
    input  cacheSel      mcCacheId,
    input  sramAddr      mcSramAddr,
    input  extAddr       mcExtAddr,
    output logic         mcBusy,
    output progressCount mcProgress,
    output logic         dcacheUsed,

    // sram side, enables active low.
    output logic         sramCeN,
    output logic         sramWeN,
    output cacheSel      sramSel,
    output sramAddr      sramAddrOut,
    output dataWord      sramWrData,
    output byteMask      sramWrMask,
    input  dataWord      sramRdData,

    // external bus.
    output logic         extEn,
    output logic         extOen,
    output dataWord      extBusOut,
    input  dataWord      extBusIn
);

    ctrlState state;
    logic storeMode;
    logic [beatBits-1:0] beat;
    sramAddr nextAddr;

    logic accept;
    logic issueRead;
    logic sendWord;
    logic takeWord;

    // no path from the instruction sram to the bus, so such stores are dropped.
    assign accept = mcCe && !mcBusy && !(mcWe && mcCacheId == selIcache);

    // beat equals the cycle number since the strobe.
    assign issueRead = storeMode && (state == command || state == stream) && beat < burstLen;
    assign sendWord = storeMode && state == stream && beat <= burstLen + 1;
    assign takeWord = !storeMode && state == stream && beat >= 3;

    // controller always moves whole words.
    assign sramWrMask = '1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
            storeMode <= 1'b0;
            beat <= '0;
            mcBusy <= 1'b0;
            extEn <= 1'b0;
            extOen <= 1'b0;
            dcacheUsed <= 1'b0;
            mcProgress <= '0;
            sramCeN <= 1'b1;
            sramWeN <= 1'b1;
        end else begin
            // first store read goes out together with the command word.
            sramCeN <= !(issueRead || takeWord || (accept && mcWe));
            sramWeN <= !takeWord;
            extOen <= accept || sendWord;

            if (state == idle) begin
                beat <= beatBits'(1);
            end else begin
                beat <= beat + 1'b1;
            end

            if (sendWord || takeWord) begin
                mcProgress <= mcProgress + 1'b1;
            end

            case (state)
                idle: begin
                    if (accept) begin
                        state <= command;
                        storeMode <= mcWe;
                        mcBusy <= 1'b1;
                        extEn <= 1'b1;
                        dcacheUsed <= (mcCacheId == selDcache);
                        mcProgress <= '0;
                    end
                end
                command: begin
                    state <= stream;
                end
                stream: begin
                    // last load word arrives here.
                    if (beat == burstLen + 2) begin
                        state <= drain;
                    end
                end
                drain: begin
                    state <= idle;
                    mcBusy <= 1'b0;
                    extEn <= 1'b0;
                    dcacheUsed <= 1'b0;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sramSel <= mcCacheId;
            sramAddrOut <= mcSramAddr;
            nextAddr <= mcSramAddr + sramAddr'(mcWe);
            extBusOut <= cmdWord(mcWe, mcExtAddr);
        end

        if (issueRead || takeWord) begin
            sramAddrOut <= nextAddr;
            nextAddr <= nextAddr + 1'b1;
        end

        // load word is written one cycle after it is on the bus.
        if (takeWord) begin
            sramWrData <= extBusIn;
        end

        if (sendWord) begin
            extBusOut <= sramRdData;
        end
    end

endmodule

// File: rtl/memSubsystem.sv
module memSubsystem
    import memPkg::*, xferPkg::*;
(
    input  logic         clk,
    input  logic         rstN,

    // core ports, enables are active low like the sram enables.
    input  logic         coreWriteEnable,
    input  wordAddr      coreWriteAddr,
    input  dataWord      coreWriteData,
    input  byteMask      coreWriteMask,
    input  logic         coreReadEnable,
    input  wordAddr      coreReadAddr,
    output dataWord      coreReadData,
    input  logic         instrReadEnable,
    input  lineAddr      instrReadAddr,
    output lineWord      instrReadData,

    // transfer commands.
    input  logic         mcCe,
    input  logic         mcWe,
    input  cacheSel      mcCacheId,
    input  sramAddr      mcSramAddr,
    input  extAddr       mcExtAddr,
    output logic         mcBusy,
    output progressCount mcProgress,

    // external bus.
    output logic         extEn,
    output logic         extOen,
    output dataWord      extBusOut,
    input  dataWord      extBusIn
);

    logic    dcacheUsed;
    logic    ctrlCeN;
    logic    ctrlWeN;
    cacheSel ctrlSel;
    sramAddr ctrlAddr;
    dataWord ctrlWrData;
    byteMask ctrlWrMask;
    dataWord dcRdData;

    logic    dcCeN;
    logic    dcWeN;
    sramAddr dcAddr;
    dataWord dcWrData;
    byteMask dcWrMask;
    logic    dcReadCeN;

    logic    icCeN;
    lineMask icWrMask;

    memController memCtrl_i (
        .clk        (clk),
        .rstN       (rstN),
        .mcCe       (mcCe),
        .mcWe       (mcWe),
        .mcCacheId  (mcCacheId),
        .mcSramAddr (mcSramAddr),
        .mcExtAddr  (mcExtAddr),
        .mcBusy     (mcBusy),
        .mcProgress (mcProgress),
        .dcacheUsed (dcacheUsed),
        .sramCeN    (ctrlCeN),
        .sramWeN    (ctrlWeN),
        .sramSel    (ctrlSel),
        .sramAddrOut(ctrlAddr),
        .sramWrData (ctrlWrData),
        .sramWrMask (ctrlWrMask),
        .sramRdData (dcRdData),
        .extEn      (extEn),
        .extOen     (extOen),
        .extBusOut  (extBusOut),
        .extBusIn   (extBusIn)
    );

    // controller owns port 0 during its bursts; core writes are lost then.
    always_comb begin
        if (dcacheUsed) begin
            dcCeN = ctrlCeN;
            dcWeN = ctrlWeN;
            dcAddr = ctrlAddr;
            dcWrData = ctrlWrData;
            dcWrMask = ctrlWrMask;
        end else begin
            dcCeN = coreWriteEnable || coreWriteAddr >= dcacheDepth;
            dcWeN = 1'b0;
            dcAddr = coreWriteAddr[sramAddrBits-1:0];
            dcWrData = coreWriteData;
            dcWrMask = coreWriteMask;
        end
    end

    // out of range read keeps the last data.
    assign dcReadCeN = coreReadEnable || coreReadAddr >= dcacheDepth;

    sramDualPort #(
        .dataWidth(dataBits),
        .depth    (dcacheDepth)
    ) dcache_i (
        .clk    (clk),
        .ceN    (dcCeN),
        .weN    (dcWeN),
        .addr   (dcAddr),
        .wrData (dcWrData),
        .wrMask (dcWrMask),
        .rdData (dcRdData),
        .ceN1   (dcReadCeN),
        .addr1  (coreReadAddr[sramAddrBits-1:0]),
        .rdData1(coreReadData)
    );

    // odd word index goes to the upper half of the line.
    assign icCeN = ctrlCeN || ctrlSel != selIcache;
    assign icWrMask = ctrlAddr[0] ? {ctrlWrMask, byteMask'(0)} : {byteMask'(0), ctrlWrMask};

    sramDualPort #(
        .dataWidth(lineBits),
        .depth    (icacheDepth)
    ) icache_i (
        .clk    (clk),
        .ceN    (icCeN),
        .weN    (ctrlWeN),
        .addr   (ctrlAddr[sramAddrBits-1:1]),
        .wrData ({ctrlWrData, ctrlWrData}),
        .wrMask (icWrMask),
        .rdData (),
        .ceN1   (instrReadEnable),
        .addr1  (instrReadAddr),
        .rdData1(instrReadData)
    );

endmodule

// File: sim/extMemModel.sv
module extMemModel
    import memPkg::*, xferPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    extEn,
    input  logic    extOen,
    input  dataWord bus,
    output logic    drive,
    output dataWord driveData,

    // lookup of stored words for the testbench.
    input  extAddr  peekAddr,
    output dataWord peekData
);

    dataWord mem [extAddr];
    logic prevEn;
    logic isWrite;
    extAddr base;
    int beat;

    // words never written hold an address pattern.
    function automatic dataWord readWord(input extAddr a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return dataWord'(a) ^ 32'hA5A50000;
    endfunction

    assign peekData = readWord(peekAddr);

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            prevEn <= 1'b0;
            isWrite <= 1'b0;
            base <= '0;
            beat <= 0;
            drive <= 1'b0;
            driveData <= '0;
        end else begin
            prevEn <= extEn;
            drive <= 1'b0;
            if (extEn && !prevEn && extOen) begin
                // command word opens the burst.
                isWrite <= bus[cmdWriteBit];
                base <= bus[extAddrBits-1:0];
                beat <= 0;
            end else if (extEn) begin
                beat <= beat + 1;
                if (!isWrite && beat < burstLen) begin
                    drive <= 1'b1;
                    driveData <= readWord(base + extAddr'(beat));
                end
                // store word k is on the bus one beat after the read word would be.
                if (isWrite && extOen && beat >= 1 && beat <= burstLen) begin
                    mem[base + extAddr'(beat - 1)] = bus;
                end
            end
        end
    end

endmodule

// File: sim/memSubsystem_assert.sv
module memSubsystemAssert
    import xferPkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  logic         mcCe,
    input  logic         mcWe,
    input  cacheSel      mcCacheId,
    input  logic         mcBusy,
    input  logic         extEn,
    input  logic         extOen,
    input  progressCount mcProgress,
    input  logic         dcacheUsed,
    input  logic         storeMode
);

    int enFails = 0;
    int lenFails = 0;
    int oenFails = 0;
    int progFails = 0;
    int resetFails = 0;
    int failCount;
    int busyCount;
    logic accepted;

    assign failCount = enFails + lenFails + oenFails + progFails + resetFails;
    assign accepted = mcCe && !mcBusy && !(mcWe && mcCacheId == selIcache);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busyCount <= 0;
        end else if (mcBusy) begin
            busyCount <= busyCount + 1;
        end else begin
            busyCount <= 0;
        end
    end

    enMatch: assert property (@(posedge clk) disable iff (!rstN) extEn == mcBusy)
        else begin
            $error("extEn and mcBusy differ");
            enFails++;
        end

    busyStart: assert property (@(posedge clk) disable iff (!rstN) accepted |=> mcBusy)
        else begin
            $error("accepted strobe did not raise mcBusy");
            lenFails++;
        end

    // busy window is cycles 1 through burstLen+3.
    busyLength: assert property (@(posedge clk) disable iff (!rstN)
        $fell(mcBusy) |-> busyCount == burstLen + 3)
        else begin
            $error("mcBusy lasted %0d cycles", busyCount);
            lenFails++;
        end

    // store words occupy cycles 3 through burstLen+2.
    oenWindow: assert property (@(posedge clk) disable iff (!rstN)
        extOen |-> mcBusy && ($rose(mcBusy)
            || (storeMode && busyCount >= 2 && busyCount <= burstLen + 1)))
        else begin
            $error("extOen high outside command and store cycles");
            oenFails++;
        end

    progressUp: assert property (@(posedge clk) disable iff (!rstN)
        mcBusy && $past(mcBusy) |-> mcProgress >= $past(mcProgress))
        else begin
            $error("mcProgress went down during a burst");
            progFails++;
        end

    resetLow: assert property (@(posedge clk)
        !rstN |-> !mcBusy && !extEn && !extOen && !dcacheUsed && mcProgress == '0)
        else begin
            $error("controls not cleared by reset");
            resetFails++;
        end

endmodule

bind memSubsystem memSubsystemAssert assert_i (
    .clk       (clk),
    .rstN      (rstN),
    .mcCe      (mcCe),
    .mcWe      (mcWe),
    .mcCacheId (mcCacheId),
    .mcBusy    (mcBusy),
    .extEn     (extEn),
    .extOen    (extOen),
    .mcProgress(mcProgress),
    .dcacheUsed(dcacheUsed),
    .storeMode (memCtrl_i.storeMode)
);

// File: sim/memSubsystemTb.sv
module memSubsystemTb
    import memPkg::*, xferPkg::*;
();

    localparam int clkPeriod = 8;
    localparam int testCycles = 400;

    logic clk = 1'b0;
    logic rstN;
    logic coreWriteEnable;
    wordAddr coreWriteAddr;
    dataWord coreWriteData;
    byteMask coreWriteMask;
    logic coreReadEnable;
    wordAddr coreReadAddr;
    dataWord coreReadData;
    logic instrReadEnable;
    lineAddr instrReadAddr;
    lineWord instrReadData;
    logic mcCe;
    logic mcWe;
    cacheSel mcCacheId;
    sramAddr mcSramAddr;
    extAddr mcExtAddr;
    logic mcBusy;
    progressCount mcProgress;
    logic extEn;
    logic extOen;
    dataWord extBusOut;
    dataWord extBusIn;
    logic modelDrive;
    dataWord modelData;
    extAddr peekAddr;
    dataWord peekData;

    int seed = 58746;
    int errors = 0;
    dataWord shadow [dcacheDepth];

    always #(clkPeriod / 2) clk = ~clk;

    memSubsystem dut_i (.*);

    extMemModel extMem_i (
        .clk      (clk),
        .rstN     (rstN),
        .extEn    (extEn),
        .extOen   (extOen),
        .bus      (extBusIn),
        .drive    (modelDrive),
        .driveData(modelData),
        .peekAddr (peekAddr),
        .peekData (peekData)
    );

    // the controller drives while extOen is high, the model otherwise.
    assign extBusIn = extOen ? extBusOut : (modelDrive ? modelData : '0);

    function automatic dataWord patternAt(input extAddr a);
        return dataWord'(a) ^ 32'hA5A50000;
    endfunction

    function automatic dataWord mergeBytes(input dataWord oldWord, input dataWord newWord,
                                           input byteMask m);
        dataWord result;
        result = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                result[b*8 +: 8] = newWord[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic writeCore(input wordAddr a, input dataWord d, input byteMask m);
        @(posedge clk);
        coreWriteEnable <= 1'b0;
        coreWriteAddr <= a;
        coreWriteData <= d;
        coreWriteMask <= m;
        @(posedge clk);
        coreWriteEnable <= 1'b1;
    endtask

    task automatic readCore(input wordAddr a, output dataWord d);
        @(posedge clk);
        coreReadEnable <= 1'b0;
        coreReadAddr <= a;
        @(posedge clk);
        coreReadEnable <= 1'b1;
        @(negedge clk);
        d = coreReadData;
    endtask

    task automatic readLine(input lineAddr a, output lineWord d);
        @(posedge clk);
        instrReadEnable <= 1'b0;
        instrReadAddr <= a;
        @(posedge clk);
        instrReadEnable <= 1'b1;
        @(negedge clk);
        d = instrReadData;
    endtask

    task automatic startBurst(input logic we, input cacheSel sel, input sramAddr s,
                              input extAddr e);
        @(posedge clk);
        mcCe <= 1'b1;
        mcWe <= we;
        mcCacheId <= sel;
        mcSramAddr <= s;
        mcExtAddr <= e;
        @(posedge clk);
        mcCe <= 1'b0;
    endtask

    task automatic waitBurst();
        int n;
        n = 0;
        @(negedge clk);
        if (!mcBusy) begin
            $display("burst command was not accepted");
            errors++;
        end
        while (mcBusy && n < testCycles) begin
            @(negedge clk);
            n++;
        end
        if (mcBusy) begin
            $display("burst did not finish within %0d cycles", testCycles);
            errors++;
        end
        // every burst moves burstLen words.
        checkValue("burstProgress", 64'(burstLen), 64'(mcProgress));
    endtask

    task automatic maskedWrites();
        sramAddr a;
        dataWord d;
        byteMask m;
        dataWord got;
        for (int i = 0; i < 20; i++) begin
            a = sramAddr'($random(seed));
            d = $random(seed);
            writeCore(wordAddr'(a), d, 4'hf);
            shadow[a] = d;
            d = $random(seed);
            m = byteMask'($random(seed));
            writeCore(wordAddr'(a), d, m);
            shadow[a] = mergeBytes(shadow[a], d, m);
            readCore(wordAddr'(a), got);
            checkValue("maskedWrite", 64'(shadow[a]), 64'(got));
        end
    endtask

    task automatic outOfRange();
        dataWord d;
        dataWord got;
        d = $random(seed);
        writeCore(wordAddr'(7), d, 4'hf);
        shadow[7] = d;
        writeCore(wordAddr'(8), ~d, 4'hf);
        shadow[8] = ~d;
        writeCore(wordAddr'(dcacheDepth + 7), ~d, 4'hf);
        readCore(wordAddr'(7), got);
        checkValue("highWrite", 64'(shadow[7]), 64'(got));
        // read data must hold the word just read.
        readCore(wordAddr'(3 * dcacheDepth + 8), got);
        checkValue("highRead", 64'(shadow[7]), 64'(got));
    endtask

    task automatic checkLoaded(input string name, input sramAddr s, input extAddr e);
        dataWord got;
        for (int k = 0; k < burstLen; k++) begin
            shadow[s + sramAddr'(k)] = patternAt(e + extAddr'(k));
            readCore(wordAddr'(s + sramAddr'(k)), got);
            checkValue(name, 64'(shadow[s + sramAddr'(k)]), 64'(got));
        end
    endtask

    task automatic loadData(input sramAddr s, input extAddr e);
        startBurst(1'b0, selDcache, s, e);
        waitBurst();
        checkLoaded("loadData", s, e);
    endtask

    task automatic storeData(input sramAddr s, input extAddr e);
        dataWord d;
        for (int k = 0; k < burstLen; k++) begin
            d = $random(seed);
            writeCore(wordAddr'(s + sramAddr'(k)), d, 4'hf);
            shadow[s + sramAddr'(k)] = d;
        end
        startBurst(1'b1, selDcache, s, e);
        waitBurst();
        for (int k = 0; k < burstLen; k++) begin
            peekAddr = e + extAddr'(k);
            #1;
            checkValue("storeData", 64'(shadow[s + sramAddr'(k)]), 64'(peekData));
        end
    endtask

    task automatic loadInstr(input sramAddr s, input extAddr e);
        lineWord expected;
        lineWord got;
        startBurst(1'b0, selIcache, s, e);
        waitBurst();
        for (int i = 0; i < burstLen / 2; i++) begin
            expected = {patternAt(e + extAddr'(2 * i + 1)), patternAt(e + extAddr'(2 * i))};
            readLine(lineAddr'(s / 2) + lineAddr'(i), got);
            checkValue("loadInstr", expected, got);
        end
    endtask

    task automatic busyOverlap(input extAddr e);
        startBurst(1'b0, selDcache, 10'd500, e);
        repeat (10) @(posedge clk);
        // strobe and core write both fall inside the running burst.
        startBurst(1'b0, selDcache, 10'd600, e + 30'h100);
        writeCore(wordAddr'(500), $random(seed), 4'hf);
        waitBurst();
        repeat (4) @(negedge clk);
        if (mcBusy) begin
            $display("strobe during busy started a second burst");
            errors++;
        end
        checkLoaded("busyOverlap", 10'd500, e);
    endtask

    initial begin
        rstN <= 1'b0;
        coreWriteEnable <= 1'b1;
        coreWriteAddr <= '0;
        coreWriteData <= '0;
        coreWriteMask <= '0;
        coreReadEnable <= 1'b1;
        coreReadAddr <= '0;
        instrReadEnable <= 1'b1;
        instrReadAddr <= '0;
        mcCe <= 1'b0;
        mcWe <= 1'b0;
        mcCacheId <= selDcache;
        mcSramAddr <= '0;
        mcExtAddr <= '0;
        peekAddr = '0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        repeat (2) @(posedge clk);

        maskedWrites();
        outOfRange();
        loadData(10'd100, extAddr'($random(seed)));
        storeData(10'd300, extAddr'($random(seed)));
        loadInstr(10'd40, extAddr'($random(seed)));
        busyOverlap(extAddr'($random(seed)));

        repeat (2) @(posedge clk);
        $display("data check errors: %0d, assertion failures: %0d",
                 errors, dut_i.assert_i.failCount);
        if (errors == 0 && dut_i.assert_i.failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // six tests of at most testCycles cycles each.
    initial begin
        #(6 * testCycles * clkPeriod);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: vlog.f
rtl/memPkg.sv
rtl/xferPkg.sv
rtl/sramDualPort.sv
rtl/memController.sv
rtl/memSubsystem.sv
sim/extMemModel.sv
sim/memSubsystem_assert.sv
sim/memSubsystemTb.sv

// File: Makefile
SIM      = verilator
TOP      = memSubsystemTb
FILELIST = vlog.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
RUNFLAGS = +verilator+error+limit+1000
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
